// ==== filelist.f ====
+incdir+include
rtl/trace_pkg.sv
rtl/store_snoop_if.sv
rtl/trace_fifo.sv
rtl/print_capture.sv
rtl/sync_profiler.sv
rtl/trace_apb_regs.sv
rtl/trace_monitor_top.sv
sim/tb_clk_gen.sv
sim/trace_tb.sv

// ==== include/trace_macros.svh ====
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Number of tiles under observation
`define TRACE_N_TILES 4

// Print peripheral addresses, aliased for every tile
`define TRACE_STDERR_ADDR 32'hFFFF_0000
`define TRACE_STDOUT_ADDR 32'hFFFF_0004

// Sentinels are nop forms of addi x0, x0, imm
`define TRACE_SENT_START 32'h5AA0_0013
`define TRACE_SENT_END   32'h5FF0_0013

// Buffer depths
`define TRACE_CHAR_DEPTH 8
`define TRACE_SYNC_DEPTH 4

// APB register offsets, per-tile banks use a stride of 4
`define TRACE_REG_STATUS    8'h00
`define TRACE_REG_CHAR_BASE 8'h10
`define TRACE_REG_ERR_BASE  8'h20
`define TRACE_REG_SYNC      8'h30
`define TRACE_REG_TIMER     8'h34

`endif

// ==== rtl/print_capture.sv ====
`timescale 1ns/1ps
`include "trace_macros.svh"

module print_capture (
  input  logic             clk,
  input  logic             i_rst_n,
  store_snoop_if.mon       snoop,
  input  logic             i_pop,
  input  logic             i_ovf_clr,
  output trace_pkg::char_t o_char,
  output logic             o_char_avail,
  output logic             o_ovf,
  output trace_pkg::char_t o_err_code,
  output logic             o_err_valid
);
  import trace_pkg::*;

  logic out_armed;
  logic err_armed;
  logic out_hit;
  logic err_hit;

  // Data beats use the arm state from before this cycle
  assign out_hit = snoop.w_valid && out_armed;
  assign err_hit = snoop.w_valid && err_armed;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      out_armed <= 1'b0;
      err_armed <= 1'b0;
    end else begin
      // A data beat consumes the arm
      if (snoop.w_valid) begin
        out_armed <= 1'b0;
        err_armed <= 1'b0;
      end
      // A new address beat re-arms, or disarms for non-print stores
      if (snoop.aw_valid) begin
        out_armed <= (snoop.aw_addr == `TRACE_STDOUT_ADDR);
        err_armed <= (snoop.aw_addr == `TRACE_STDERR_ADDR);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (err_hit) begin
      o_err_code <= snoop.w_data;
    end
  end

  // One-cycle strobe marking a freshly latched error code
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_err_valid <= 1'b0;
    end else begin
      o_err_valid <= err_hit;
    end
  end

  trace_fifo #(
    .payload_t (char_t),
    .DEPTH     (`TRACE_CHAR_DEPTH)
  ) u_char_fifo (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_push      (out_hit),
    .i_data      (snoop.w_data),
    .i_pop       (i_pop),
    .i_ovf_clr   (i_ovf_clr),
    .o_data      (o_char),
    .o_not_empty (o_char_avail),
    .o_ovf       (o_ovf)
  );

  a_one_arm: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(out_armed && err_armed))
    else $error("print_capture: stdout and stderr armed together");

endmodule

// ==== rtl/store_snoop_if.sv ====
`timescale 1ns/1ps

interface store_snoop_if;
  import trace_pkg::*;

  // Address beat of a store
  logic  aw_valid;
  addr_t aw_addr;

  // Low byte of the matching data beat
  logic  w_valid;
  char_t w_data;

  // Driving side, loaded by the top level
  modport src (output aw_valid, output aw_addr, output w_valid, output w_data);

  // Observing side
  modport mon (input aw_valid, input aw_addr, input w_valid, input w_data);

endinterface

// ==== rtl/sync_profiler.sv ====
`timescale 1ns/1ps
`include "trace_macros.svh"

module sync_profiler (
  input  logic                                    clk,
  input  logic                                    i_rst_n,
  input  logic              [`TRACE_N_TILES-1:0] i_ex_valid,
  input  trace_pkg::instr_t [`TRACE_N_TILES-1:0] i_ex_instr,
  input  logic                                    i_pop,
  output trace_pkg::sync_rec_t                    o_sync,
  output logic                                    o_sync_avail,
  output trace_pkg::cycle_t                       o_timer
);
  import trace_pkg::*;

  localparam int NT = `TRACE_N_TILES;

  cycle_t        timer;
  cycle_t        start_ts [NT];
  cycle_t        end_ts   [NT];
  logic [NT-1:0] is_start;
  logic [NT-1:0] is_end;
  logic [NT-1:0] started;
  logic [NT-1:0] done;
  logic          all_done;
  logic          comp_valid;
  cycle_t        last_start;
  cycle_t        last_end;
  cycle_t        sync_diff;
  sync_rec_t     comp_rec;

  always_comb begin
    for (int t = 0; t < NT; t++) begin
      is_start[t] = i_ex_valid[t] && (i_ex_instr[t] == `TRACE_SENT_START);
      is_end[t]   = i_ex_valid[t] && (i_ex_instr[t] == `TRACE_SENT_END);
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < NT; t++) begin
      if (is_start[t]) start_ts[t] <= timer;
      if (is_end[t])   end_ts[t]   <= timer;
    end
  end

  // Latest start and latest end across the round
  always_comb begin
    last_start = '0;
    last_end   = '0;
    for (int t = 0; t < NT; t++) begin
      if (start_ts[t] > last_start) last_start = start_ts[t];
      if (end_ts[t] > last_end)     last_end   = end_ts[t];
    end
  end

  // One cycle of sentinel overhead is taken off
  assign sync_diff = last_end - last_start - 1'b1;
  assign all_done  = &done;
  assign o_timer   = timer;

  always_ff @(posedge clk) begin
    if (all_done && !comp_valid) begin
      comp_rec <= sync_diff[SYNC_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      timer      <= '0;
      started    <= '0;
      done       <= '0;
      comp_valid <= 1'b0;
    end else begin
      timer      <= timer + 1'b1;
      // Fires once per round, done flags clear as the record is pushed
      comp_valid <= all_done && !comp_valid;
      started    <= (started & ~{NT{comp_valid}}) | is_start;
      done       <= (done & ~{NT{comp_valid}}) | is_end;
    end
  end

  trace_fifo #(
    .payload_t (sync_rec_t),
    .DEPTH     (`TRACE_SYNC_DEPTH)
  ) u_sync_fifo (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_push      (comp_valid),
    .i_data      (comp_rec),
    .i_pop       (i_pop),
    .i_ovf_clr   (1'b0),
    .o_data      (o_sync),
    .o_not_empty (o_sync_avail),
    .o_ovf       ()
  );

  for (genvar t = 0; t < NT; t++) begin : g_chk
    a_end_after_start: assert property (@(posedge clk) disable iff (!i_rst_n)
      is_end[t] |-> started[t])
      else $error("sync_profiler: end sentinel without start on tile %0d", t);
  end

endmodule

// ==== rtl/trace_apb_regs.sv ====
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_apb_regs (
  input  logic                                       clk,
  input  logic                                       i_rst_n,
  input  logic                                       i_psel,
  input  logic                                       i_penable,
  input  logic                                       i_pwrite,
  input  trace_pkg::addr_t                           i_paddr,
  input  logic                 [31:0]                i_pwdata,
  input  trace_pkg::char_t     [`TRACE_N_TILES-1:0] i_char,
  input  logic                 [`TRACE_N_TILES-1:0] i_char_avail,
  input  logic                 [`TRACE_N_TILES-1:0] i_ovf,
  input  trace_pkg::char_t     [`TRACE_N_TILES-1:0] i_err_code,
  input  logic                 [`TRACE_N_TILES-1:0] i_err_valid,
  input  trace_pkg::sync_rec_t                       i_sync,
  input  logic                                       i_sync_avail,
  input  trace_pkg::cycle_t                          i_timer,
  output logic                 [31:0]                o_prdata,
  output logic                                       o_pready,
  output logic                                       o_pslverr,
  output logic                 [`TRACE_N_TILES-1:0] o_char_pop,
  output logic                 [`TRACE_N_TILES-1:0] o_ovf_clr,
  output logic                                       o_sync_pop
);
  import trace_pkg::*;

  localparam int NT = `TRACE_N_TILES;

  logic                  access;
  logic                  rd_acc;
  logic                  wr_acc;
  logic [7:0]            offset;
  logic [7:0]            char_rel;
  logic [7:0]            err_rel;
  logic                  in_page;
  logic                  hit_status;
  logic                  hit_char;
  logic                  hit_err;
  logic                  hit_sync;
  logic                  hit_timer;
  logic                  mapped;
  logic [TILE_IDX_W-1:0] char_idx;
  logic [TILE_IDX_W-1:0] err_idx;
  logic [NT-1:0]         err_flag;
  logic [NT-1:0]         err_vis;
  logic [NT-1:0]         err_rd;

  // Zero wait states, every access ends in its access phase
  assign o_pready = 1'b1;
  assign access   = i_psel && i_penable;
  assign rd_acc   = access && !i_pwrite;
  assign wr_acc   = access && i_pwrite;

  assign offset  = i_paddr[7:0];
  assign in_page = (i_paddr[31:8] == '0) && (offset[1:0] == 2'b00);

  // Offsets below a bank base wrap to large values and miss
  assign char_rel = offset - `TRACE_REG_CHAR_BASE;
  assign err_rel  = offset - `TRACE_REG_ERR_BASE;
  assign char_idx = char_rel[TILE_IDX_W+1:2];
  assign err_idx  = err_rel[TILE_IDX_W+1:2];

  assign hit_status = in_page && (offset == `TRACE_REG_STATUS);
  assign hit_char   = in_page && (char_rel < 8'(4 * NT));
  assign hit_err    = in_page && (err_rel < 8'(4 * NT));
  assign hit_sync   = in_page && (offset == `TRACE_REG_SYNC);
  assign hit_timer  = in_page && (offset == `TRACE_REG_TIMER);
  assign mapped     = hit_status || hit_char || hit_err || hit_sync || hit_timer;

  // Only STATUS takes writes
  assign o_pslverr = access && (!mapped || (i_pwrite && !hit_status));

  always_comb begin
    o_char_pop = '0;
    o_ovf_clr  = '0;
    err_rd     = '0;
    if (rd_acc && hit_char) begin
      o_char_pop[char_idx] = i_char_avail[char_idx];
    end
    if (rd_acc && hit_err) begin
      err_rd[err_idx] = 1'b1;
    end
    if (wr_acc && hit_status) begin
      o_ovf_clr = i_pwdata[16 +: NT];
    end
  end

  assign o_sync_pop = rd_acc && hit_sync && i_sync_avail;

  // Capture strobes are held here until software reads ERR
  assign err_vis = err_flag | i_err_valid;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      err_flag <= '0;
    end else begin
      err_flag <= err_vis & ~err_rd;
    end
  end

  always_comb begin
    o_prdata = '0;
    if (hit_status) begin
      o_prdata[NT-1:0]   = i_char_avail;
      o_prdata[8]        = i_sync_avail;
      o_prdata[16 +: NT] = i_ovf;
    end else if (hit_char) begin
      o_prdata = {23'b0, i_char_avail[char_idx], i_char[char_idx]};
    end else if (hit_err) begin
      o_prdata = {23'b0, err_vis[err_idx], i_err_code[err_idx]};
    end else if (hit_sync) begin
      o_prdata = {i_sync_avail, 7'b0, i_sync};
    end else if (hit_timer) begin
      o_prdata = i_timer;
    end
  end

  a_penable_in_psel: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_penable |-> i_psel)
    else $error("trace_apb_regs: PENABLE without PSEL");

endmodule

// ==== rtl/trace_fifo.sv ====
`timescale 1ns/1ps

module trace_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_push,
  input  payload_t i_data,
  input  logic     i_pop,
  input  logic     i_ovf_clr,
  output payload_t o_data,
  output logic     o_not_empty,
  output logic     o_ovf
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // Wrap also works for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count == CNT_W'(DEPTH));
  assign o_not_empty = (count != '0);
  assign do_push     = i_push && !full;
  assign do_pop      = i_pop && o_not_empty;
  assign o_data      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      o_ovf  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // A drop wins over a clear in the same cycle
      if (i_push && full) begin
        o_ovf <= 1'b1;
      end else if (i_ovf_clr) begin
        o_ovf <= 1'b0;
      end
    end
  end

  // The reader must gate its pop with the not-empty flag
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pop |-> o_not_empty)
    else $error("trace_fifo: pop while empty");

  a_count_bound: assert property (@(posedge clk) disable iff (!i_rst_n)
    count <= CNT_W'(DEPTH))
    else $error("trace_fifo: count above depth");

endmodule

// ==== rtl/trace_monitor_top.sv ====
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_monitor_top (
  input  logic                                    clk,
  input  logic                                    i_rst_n,
  // APB slave
  input  logic                                    i_psel,
  input  logic                                    i_penable,
  input  logic                                    i_pwrite,
  input  trace_pkg::addr_t                        i_paddr,
  input  logic              [31:0]                i_pwdata,
  output logic              [31:0]                o_prdata,
  output logic                                    o_pready,
  output logic                                    o_pslverr,
  // Per-tile store snoop
  input  logic              [`TRACE_N_TILES-1:0] i_aw_valid,
  input  trace_pkg::addr_t  [`TRACE_N_TILES-1:0] i_aw_addr,
  input  logic              [`TRACE_N_TILES-1:0] i_w_valid,
  input  trace_pkg::char_t  [`TRACE_N_TILES-1:0] i_w_data,
  // Per-tile execute stage
  input  logic              [`TRACE_N_TILES-1:0] i_ex_valid,
  input  trace_pkg::instr_t [`TRACE_N_TILES-1:0] i_ex_instr
);
  import trace_pkg::*;

  localparam int NT = `TRACE_N_TILES;

  char_t [NT-1:0] char_data;
  logic  [NT-1:0] char_avail;
  logic  [NT-1:0] char_ovf;
  char_t [NT-1:0] err_code;
  logic  [NT-1:0] err_valid;
  logic  [NT-1:0] char_pop;
  logic  [NT-1:0] ovf_clr;
  sync_rec_t      sync_data;
  logic           sync_avail;
  logic           sync_pop;
  cycle_t         timer;

  for (genvar t = 0; t < NT; t++) begin : g_tile
    store_snoop_if snoop ();

    assign snoop.aw_valid = i_aw_valid[t];
    assign snoop.aw_addr  = i_aw_addr[t];
    assign snoop.w_valid  = i_w_valid[t];
    assign snoop.w_data   = i_w_data[t];

    print_capture u_capture (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .snoop        (snoop),
      .i_pop        (char_pop[t]),
      .i_ovf_clr    (ovf_clr[t]),
      .o_char       (char_data[t]),
      .o_char_avail (char_avail[t]),
      .o_ovf        (char_ovf[t]),
      .o_err_code   (err_code[t]),
      .o_err_valid  (err_valid[t])
    );
  end

  sync_profiler u_profiler (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ex_valid   (i_ex_valid),
    .i_ex_instr   (i_ex_instr),
    .i_pop        (sync_pop),
    .o_sync       (sync_data),
    .o_sync_avail (sync_avail),
    .o_timer      (timer)
  );

  trace_apb_regs u_regs (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_char       (char_data),
    .i_char_avail (char_avail),
    .i_ovf        (char_ovf),
    .i_err_code   (err_code),
    .i_err_valid  (err_valid),
    .i_sync       (sync_data),
    .i_sync_avail (sync_avail),
    .i_timer      (timer),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .o_char_pop   (char_pop),
    .o_ovf_clr    (ovf_clr),
    .o_sync_pop   (sync_pop)
  );

endmodule

// ==== rtl/trace_pkg.sv ====
`include "trace_macros.svh"

package trace_pkg;

  // Data path widths
  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;
  localparam int CHAR_W  = 8;
  localparam int CYCLE_W = 32;
  localparam int SYNC_W  = 24;

  // Width of a tile index, kept at least one bit wide
  localparam int TILE_IDX_W = (`TRACE_N_TILES > 1) ? $clog2(`TRACE_N_TILES) : 1;

  // Snooped store address
  typedef logic [ADDR_W-1:0] addr_t;

  // Instruction word entering execute
  typedef logic [INSTR_W-1:0] instr_t;

  // One printed byte
  typedef logic [CHAR_W-1:0] char_t;

  // Free-running cycle count and timestamps
  typedef logic [CYCLE_W-1:0] cycle_t;

  // Measured synchronization time in cycles
  typedef logic [SYNC_W-1:0] sync_rec_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the trace monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module trace_tb -o trace_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/trace_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_NS = 4
) (
  output logic o_clk
);

  // Free-running clock, 8 ns period with the default half period
  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

endmodule

// ==== sim/trace_tb.sv ====
`timescale 1ns/1ps
`include "trace_macros.svh"

module trace_tb;
  import trace_pkg::*;

  localparam int NT      = `TRACE_N_TILES;
  localparam int TIMEOUT = 200;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  addr_t               paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic [NT-1:0]       aw_valid;
  addr_t [NT-1:0]      aw_addr;
  logic [NT-1:0]       w_valid;
  char_t [NT-1:0]      w_data;
  logic [NT-1:0]       ex_valid;
  instr_t [NT-1:0]     ex_instr;

  logic [31:0]         lcg_state;
  char_t               exp_chars [NT][$];
  char_t               exp_err [NT];
  logic [NT-1:0]       exp_ovf;
  string               chk_name [$];
  logic [31:0]         chk_exp [$];
  logic [31:0]         chk_got [$];
  string               cur_name;
  logic [31:0]         cur_exp;
  logic [31:0]         cur_got;
  int                  errors;
  int                  errs_at_start;
  int                  tests_run;
  int                  tests_failed;

  tb_clk_gen u_clk (.o_clk(clk));

  trace_monitor_top dut0 (
    .clk        (clk),
    .i_rst_n    (rst_n),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .i_aw_valid (aw_valid),
    .i_aw_addr  (aw_addr),
    .i_w_valid  (w_valid),
    .i_w_data   (w_data),
    .i_ex_valid (ex_valid),
    .i_ex_instr (ex_instr)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic addr_t reg_addr(input logic [7:0] base, input int idx);
    return {24'b0, base} + 32'(4 * idx);
  endfunction

  // Reference model of one tile's character FIFO where bytes past the depth are lost
  function automatic void model_char(input int tile, input char_t c);
    if (exp_chars[tile].size() < `TRACE_CHAR_DEPTH) begin
      exp_chars[tile].push_back(c);
    end else begin
      exp_ovf[tile] = 1'b1;
    end
  endfunction

  function automatic void model_err(input int tile, input char_t code);
    exp_err[tile] = code;
  endfunction

  // Expected STATUS with available bits at 0 and overflow bits at 16
  function automatic logic [31:0] status_expected();
    logic [31:0] s;
    s = '0;
    for (int t = 0; t < NT; t++) begin
      s[t]      = (exp_chars[t].size() > 0);
      s[16 + t] = exp_ovf[t];
    end
    return s;
  endfunction

  function automatic logic [31:0] sync_expected(input int s_cyc[NT], input int e_cyc[NT]);
    int max_s;
    int max_e;
    max_s = 0;
    max_e = 0;
    for (int t = 0; t < NT; t++) begin
      if (s_cyc[t] > max_s) begin
        max_s = s_cyc[t];
      end
      if (e_cyc[t] > max_e) begin
        max_e = e_cyc[t];
      end
    end
    return 32'(max_e - max_s - 1);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_name.push_back(name);
    chk_exp.push_back(exp);
    chk_got.push_back(got);
  endtask

  // Compare process that drains queued expectations each clock
  always @(posedge clk) begin
    while (chk_name.size() > 0) begin
      cur_name = chk_name.pop_front();
      cur_exp  = chk_exp.pop_front();
      cur_got  = chk_got.pop_front();
      if (cur_exp !== cur_got) begin
        $display("Mismatch %s exp %08h got %08h", cur_name, cur_exp, cur_got);
        errors++;
      end
    end
  end

  // Setup phase followed by an access phase sampled mid-cycle
  task automatic apb_access(input logic write, input addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] data, output logic err);
    int n;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    n = 0;
    while (pready !== 1'b1) begin
      if (n == TIMEOUT) begin
        abort_on_timeout("PREADY");
      end
      @(posedge clk);
      #3;
      n++;
    end
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic apb_write(input addr_t addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, wdata, unused, err);
  endtask

  task automatic check_read(input string name, input addr_t addr, input logic [31:0] mask,
                            input logic [31:0] exp, input logic exp_err);
    logic [31:0] d;
    logic        e;
    apb_read(addr, d, e);
    // A zero mask checks only the error response
    if (mask != '0) begin
      expect_value(name, exp & mask, d & mask);
    end
    expect_value({name, ".pslverr"}, {31'b0, exp_err}, {31'b0, e});
  endtask

  // Address beat followed by the data beat on the next cycle
  task automatic snoop_store(input int tile, input addr_t addr, input char_t data);
    @(posedge clk);
    #1;
    aw_valid[tile] = 1'b1;
    aw_addr[tile]  = addr;
    @(posedge clk);
    #1;
    aw_valid[tile] = 1'b0;
    w_valid[tile]  = 1'b1;
    w_data[tile]   = data;
    @(posedge clk);
    #1;
    w_valid[tile] = 1'b0;
  endtask

  task automatic drain_chars(input int tile);
    char_t c;
    while (exp_chars[tile].size() > 0) begin
      c = exp_chars[tile].pop_front();
      check_read($sformatf("CHAR%0d", tile), reg_addr(`TRACE_REG_CHAR_BASE, tile),
                 32'h1FF, {23'b0, 1'b1, c}, 1'b0);
    end
    check_read($sformatf("CHAR%0d.empty", tile), reg_addr(`TRACE_REG_CHAR_BASE, tile),
               32'h100, 32'h0, 1'b0);
  endtask

  // One sentinel round with cycle numbers taken from this drive loop
  task automatic sync_round(output logic [31:0] exp);
    int          s_cyc [NT];
    int          e_cyc [NT];
    int          last;
    logic [31:0] r;
    last = 0;
    for (int t = 0; t < NT; t++) begin
      r = lcg_next();
      s_cyc[t] = int'(r[17:16]);
      r = lcg_next();
      e_cyc[t] = s_cyc[t] + 1 + (int'(r[19:16]) % 12);
      if (e_cyc[t] > last) begin
        last = e_cyc[t];
      end
    end
    for (int c = 0; c <= last; c++) begin
      @(posedge clk);
      #1;
      for (int t = 0; t < NT; t++) begin
        r = lcg_next();
        ex_valid[t] = (c <= e_cyc[t]);
        if (c == s_cyc[t]) begin
          ex_instr[t] = `TRACE_SENT_START;
        end else if (c == e_cyc[t]) begin
          ex_instr[t] = `TRACE_SENT_END;
        end else begin
          // Opcode 0x33 can never match a sentinel
          ex_instr[t] = {r[31:7], 7'h33};
        end
      end
    end
    @(posedge clk);
    #1;
    ex_valid = '0;
    exp = sync_expected(s_cyc, e_cyc);
    repeat (6) @(posedge clk);
  endtask

  task automatic wait_sync_avail();
    logic [31:0] d;
    logic        e;
    int          n;
    n = 0;
    apb_read(reg_addr(`TRACE_REG_STATUS, 0), d, e);
    while (d[8] !== 1'b1) begin
      if (n == TIMEOUT) begin
        abort_on_timeout("a sync record");
      end
      apb_read(reg_addr(`TRACE_REG_STATUS, 0), d, e);
      n++;
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (chk_name.size() > 0) begin
      if (n == TIMEOUT) begin
        abort_on_timeout("the compare queue to drain");
      end
      @(posedge clk);
      #1;
      n++;
    end
    tests_run++;
    if (errors == errs_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
      tests_failed++;
    end
    errs_at_start = errors;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] t1;
    logic [31:0] t2;
    logic        e;
    int          tile;
    char_t       c;
    logic [31:0] exp_sync [3];

    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    aw_valid      = '0;
    aw_addr       = '0;
    w_valid       = '0;
    w_data        = '0;
    ex_valid      = '0;
    ex_instr      = '0;
    rst_n         = 1'b0;
    lcg_state     = 32'd32162;
    exp_ovf       = '0;
    errors        = 0;
    errs_at_start = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_read("STATUS", reg_addr(`TRACE_REG_STATUS, 0), 32'hFFFF_FFFF, status_expected(), 1'b0);
    for (int t = 0; t < NT; t++) begin
      check_read($sformatf("CHAR%0d", t), reg_addr(`TRACE_REG_CHAR_BASE, t),
                 32'h100, 32'h0, 1'b0);
      check_read($sformatf("ERR%0d", t), reg_addr(`TRACE_REG_ERR_BASE, t),
                 32'h100, 32'h0, 1'b0);
    end
    check_read("SYNC", reg_addr(`TRACE_REG_SYNC, 0), 32'h8000_0000, 32'h0, 1'b0);
    check_read("TIMER", reg_addr(`TRACE_REG_TIMER, 0), 32'h0, 32'h0, 1'b0);
    end_test("reset state");

    // Interleaved prints plus unrelated stores with at most six bytes per tile
    for (int i = 0; i < 36; i++) begin
      r    = lcg_next();
      tile = int'(r[9:8]);
      if (r[12:10] == 3'd0) begin
        snoop_store(tile, {20'h10000, r[23:14], 2'b00}, r[31:24]);
      end else if (exp_chars[tile].size() < 6) begin
        c = r[31:24];
        snoop_store(tile, `TRACE_STDOUT_ADDR, c);
        model_char(tile, c);
      end
    end
    for (int t = 0; t < NT; t++) begin
      drain_chars(t);
    end
    end_test("stdout capture");

    for (int t = 0; t < NT; t++) begin
      r = lcg_next();
      snoop_store(t, `TRACE_STDERR_ADDR, r[23:16]);
      model_err(t, r[23:16]);
    end
    for (int t = 0; t < NT; t++) begin
      check_read($sformatf("ERR%0d", t), reg_addr(`TRACE_REG_ERR_BASE, t),
                 32'h1FF, {23'b0, 1'b1, exp_err[t]}, 1'b0);
      check_read($sformatf("ERR%0d.cleared", t), reg_addr(`TRACE_REG_ERR_BASE, t),
                 32'h1FF, {23'b0, 1'b0, exp_err[t]}, 1'b0);
    end
    end_test("stderr capture");

    for (int i = 0; i < 10; i++) begin
      r = lcg_next();
      snoop_store(2, `TRACE_STDOUT_ADDR, r[27:20]);
      model_char(2, r[27:20]);
    end
    check_read("STATUS", reg_addr(`TRACE_REG_STATUS, 0), 32'hFFFF_FFFF, status_expected(), 1'b0);
    drain_chars(2);
    apb_write(reg_addr(`TRACE_REG_STATUS, 0), 32'h1 << 18, e);
    expect_value("STATUS.write.pslverr", 32'h0, {31'b0, e});
    exp_ovf[2] = 1'b0;
    check_read("STATUS", reg_addr(`TRACE_REG_STATUS, 0), 32'hFFFF_FFFF, status_expected(), 1'b0);
    end_test("character overflow");

    for (int k = 0; k < 3; k++) begin
      sync_round(exp_sync[k]);
    end
    for (int k = 0; k < 3; k++) begin
      wait_sync_avail();
      check_read($sformatf("SYNC%0d", k), reg_addr(`TRACE_REG_SYNC, 0), 32'h80FF_FFFF,
                 {1'b1, 7'b0, exp_sync[k][23:0]}, 1'b0);
    end
    check_read("STATUS", reg_addr(`TRACE_REG_STATUS, 0), 32'hFFFF_FFFF, status_expected(), 1'b0);
    end_test("sync profiling");

    check_read("UNMAPPED", 32'h0000_003C, 32'h0, 32'h0, 1'b1);
    apb_write(reg_addr(`TRACE_REG_CHAR_BASE, 0), 32'h55, e);
    expect_value("CHAR0.write.pslverr", 32'h1, {31'b0, e});
    apb_read(reg_addr(`TRACE_REG_TIMER, 0), t1, e);
    apb_read(reg_addr(`TRACE_REG_TIMER, 0), t2, e);
    if (t2 <= t1) begin
      $display("TIMER did not advance between two reads, first %08h then %08h", t1, t2);
      errors++;
    end
    end_test("errors and timer");

    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
